// File: all.f
source/wb_pkg.sv
source/io_map_pkg.sv
source/gpio_regs.sv
source/timer_regs.sv
source/io_intercon.sv
source/swervolf_io.sv
tests/swervolf_io_assert.sv
tests/tb_swervolf_io.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_swervolf_io -f all.f > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_swervolf_io > sim.log 2>&1
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "No passing verdict in sim.log"; exit 1; }
echo "Simulation passed"

// File: source/gpio_regs.sv
`default_nettype none

module gpio_regs (
   input  logic                   i_clk,
   input  logic                   i_reset,
   input  wb_pkg::wb_req_t        i_wb,
   output wb_pkg::wb_rsp_t        o_wb,
   input  io_map_pkg::gpio_pins_t i_pins,
   output io_map_pkg::gpio_pins_t o_out,
   output io_map_pkg::gpio_pins_t o_oe,
   output logic                   o_irq
);
   import wb_pkg::*;
   import io_map_pkg::*;

   gpio_pins_t out_q;
   gpio_pins_t oe_q;
   gpio_pins_t inte_q;
   gpio_pins_t ints_q;
   gpio_pins_t in_q;
   gpio_pins_t in_prev;
   gpio_pins_t rise;
   gpio_pins_t ints_clr;
   wb_word_t   rd_data;
   wb_word_t   rdt_q;
   logic       ack_q;
   logic       access;
   logic       wr_en;
   ofs_t       ofs;

   assign ofs    = i_wb.adr[OFS_W-1:0];
   // One access per strobe, none while ack is out
   assign access = i_wb.cyc & i_wb.stb & ~ack_q;
   assign wr_en  = access & i_wb.we;

   // ********************
   // Pin sampling
   // ********************

   always_ff @(posedge i_clk) begin
      in_q    <= i_pins;
      in_prev <= in_q;
   end

   assign rise     = in_q & ~in_prev;
   assign ints_clr = (wr_en && ofs == GPIO_INTS) ? gpio_pins_t'(i_wb.dat) : '0;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         out_q  <= '0;
         oe_q   <= '0;
         inte_q <= '0;
         ints_q <= '0;
         ack_q  <= 1'b0;
      end else begin
         ack_q <= access;
         if (wr_en && ofs == GPIO_OUT)
            out_q <= gpio_pins_t'(i_wb.dat);
         if (wr_en && ofs == GPIO_OE)
            oe_q <= gpio_pins_t'(i_wb.dat);
         if (wr_en && ofs == GPIO_INTE)
            inte_q <= gpio_pins_t'(i_wb.dat);
         // New edges win over a clear in the same cycle
         ints_q <= (ints_q & ~ints_clr) | rise;
      end
   end

   // ********************
   // Read back
   // ********************

   always_comb begin
      case (ofs)
         GPIO_IN:   rd_data = wb_word_t'(in_q);
         GPIO_OUT:  rd_data = wb_word_t'(out_q);
         GPIO_OE:   rd_data = wb_word_t'(oe_q);
         GPIO_INTE: rd_data = wb_word_t'(inte_q);
         GPIO_INTS: rd_data = wb_word_t'(ints_q);
         default:   rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access)
         rdt_q <= rd_data;
   end

   always_comb begin
      o_wb.rdt = rdt_q;
      o_wb.ack = ack_q;
      o_wb.err = 1'b0;
   end

   assign o_out = out_q;
   assign o_oe  = oe_q;
   assign o_irq = |(ints_q & inte_q);

endmodule

`default_nettype wire

// File: source/io_intercon.sv
`default_nettype none

module io_intercon (
   input  logic                i_clk,
   input  logic                i_reset,
   input  wb_pkg::wb_req_t     i_wb,
   output wb_pkg::wb_rsp_t     o_wb,
   output wb_pkg::wb_req_t     o_gpio_wb,
   output wb_pkg::wb_req_t     o_timer_wb,
   input  wb_pkg::wb_rsp_t     i_gpio_rsp,
   input  wb_pkg::wb_rsp_t     i_timer_rsp,
   input  logic                i_gpio_irq,
   input  logic                i_timer_irq,
   output io_map_pkg::io_irq_t o_irq
);
   import wb_pkg::*;
   import io_map_pkg::*;

   wb_adr_t win;
   logic    gpio_hit;
   logic    timer_hit;
   logic    miss_stb;
   logic    err_q;

   // ********************
   // Address decode
   // ********************

   assign win       = i_wb.adr & WIN_MASK;
   assign gpio_hit  = (win == GPIO_BASE);
   assign timer_hit = (win == TIMER_BASE);
   assign miss_stb  = i_wb.cyc & i_wb.stb & ~gpio_hit & ~timer_hit;

   // Strobe only reaches the addressed slave
   always_comb begin
      o_gpio_wb      = i_wb;
      o_gpio_wb.stb  = i_wb.stb & gpio_hit;
      o_timer_wb     = i_wb;
      o_timer_wb.stb = i_wb.stb & timer_hit;
   end

   // Unmapped access, one err pulse per strobe
   always_ff @(posedge i_clk) begin
      if (i_reset)
         err_q <= 1'b0;
      else
         err_q <= miss_stb & ~err_q;
   end

   // ********************
   // Response path
   // ********************

   always_comb begin
      if (gpio_hit) begin
         o_wb = i_gpio_rsp;
      end else if (timer_hit) begin
         o_wb = i_timer_rsp;
      end else begin
         o_wb.rdt = '0;
         o_wb.ack = 1'b0;
         o_wb.err = err_q;
      end
   end

   always_comb begin
      o_irq.gpio  = i_gpio_irq;
      o_irq.timer = i_timer_irq;
   end

endmodule

`default_nettype wire

// File: source/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

   // ********************
   // Address map
   // ********************

   // 64-byte windows
   localparam wb_pkg::wb_adr_t GPIO_BASE  = 16'h0100;
   localparam wb_pkg::wb_adr_t TIMER_BASE = 16'h0200;
   localparam wb_pkg::wb_adr_t WIN_MASK   = 16'hFFC0;

   // Offset bits inside a window
   localparam int OFS_W = 6;
   typedef logic [OFS_W-1:0] ofs_t;

   // GPIO registers
   localparam ofs_t GPIO_IN   = 6'h00;
   localparam ofs_t GPIO_OUT  = 6'h04;
   localparam ofs_t GPIO_OE   = 6'h08;
   localparam ofs_t GPIO_INTE = 6'h0C;
   localparam ofs_t GPIO_INTS = 6'h10;

   // Timer registers
   localparam ofs_t TMR_CNTR = 6'h00;
   localparam ofs_t TMR_HRC  = 6'h04;
   localparam ofs_t TMR_CTRL = 6'h08;

   // Timer control bits
   localparam int CTRL_EN  = 0;
   localparam int CTRL_IE  = 1;
   localparam int CTRL_INT = 2;

   localparam int GPIO_W = 32;
   typedef logic [GPIO_W-1:0] gpio_pins_t;

   typedef struct packed {
      logic gpio;
      logic timer;
   } io_irq_t;

endpackage

`default_nettype wire

// File: source/swervolf_io.sv
`default_nettype none

module swervolf_io (
   input  logic                   i_clk,
   input  logic                   i_reset,
   input  wb_pkg::wb_req_t        i_wb,
   output wb_pkg::wb_rsp_t        o_wb,
   input  io_map_pkg::gpio_pins_t i_gpio_in,
   output io_map_pkg::gpio_pins_t o_gpio_out,
   output io_map_pkg::gpio_pins_t o_gpio_oe,
   output io_map_pkg::io_irq_t    o_irq
);

   wb_pkg::wb_req_t gpio_wb;
   wb_pkg::wb_req_t timer_wb;
   wb_pkg::wb_rsp_t gpio_rsp;
   wb_pkg::wb_rsp_t timer_rsp;
   logic            gpio_irq;
   logic            timer_irq;

   io_intercon intercon (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_wb        (i_wb),
      .o_wb        (o_wb),
      .o_gpio_wb   (gpio_wb),
      .o_timer_wb  (timer_wb),
      .i_gpio_rsp  (gpio_rsp),
      .i_timer_rsp (timer_rsp),
      .i_gpio_irq  (gpio_irq),
      .i_timer_irq (timer_irq),
      .o_irq       (o_irq)
   );

   gpio_regs gpio (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_wb    (gpio_wb),
      .o_wb    (gpio_rsp),
      .i_pins  (i_gpio_in),
      .o_out   (o_gpio_out),
      .o_oe    (o_gpio_oe),
      .o_irq   (gpio_irq)
   );

   timer_regs timer (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_wb    (timer_wb),
      .o_wb    (timer_rsp),
      .o_irq   (timer_irq)
   );

endmodule

`default_nettype wire

// File: source/timer_regs.sv
`default_nettype none

module timer_regs (
   input  logic            i_clk,
   input  logic            i_reset,
   input  wb_pkg::wb_req_t i_wb,
   output wb_pkg::wb_rsp_t o_wb,
   output logic            o_irq
);
   import wb_pkg::*;
   import io_map_pkg::*;

   wb_word_t          cntr_q;
   wb_word_t          hrc_q;
   logic [CTRL_INT:0] ctrl_q;
   wb_word_t          rd_data;
   wb_word_t          rdt_q;
   logic              ack_q;
   logic              access;
   logic              wr_en;
   logic              wrap;
   ofs_t              ofs;

   assign ofs    = i_wb.adr[OFS_W-1:0];
   assign access = i_wb.cyc & i_wb.stb & ~ack_q;
   assign wr_en  = access & i_wb.we;

   // Compare match while running
   assign wrap = ctrl_q[CTRL_EN] && (cntr_q == hrc_q);

   // ********************
   // Counter and control
   // ********************

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         cntr_q <= '0;
         hrc_q  <= '0;
         ctrl_q <= '0;
         ack_q  <= 1'b0;
      end else begin
         ack_q <= access;
         if (wr_en && ofs == TMR_CNTR)
            cntr_q <= i_wb.dat;
         else if (wrap)
            cntr_q <= '0;
         else if (ctrl_q[CTRL_EN])
            cntr_q <= cntr_q + 1'b1;
         if (wr_en && ofs == TMR_HRC)
            hrc_q <= i_wb.dat;
         if (wr_en && ofs == TMR_CTRL) begin
            ctrl_q[CTRL_EN] <= i_wb.dat[CTRL_EN];
            ctrl_q[CTRL_IE] <= i_wb.dat[CTRL_IE];
         end
         // Match sets INT ahead of a software clear
         if (wrap)
            ctrl_q[CTRL_INT] <= 1'b1;
         else if (wr_en && ofs == TMR_CTRL && i_wb.dat[CTRL_INT])
            ctrl_q[CTRL_INT] <= 1'b0;
      end
   end

   always_comb begin
      case (ofs)
         TMR_CNTR: rd_data = cntr_q;
         TMR_HRC:  rd_data = hrc_q;
         TMR_CTRL: rd_data = wb_word_t'(ctrl_q);
         default:  rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access)
         rdt_q <= rd_data;
   end

   always_comb begin
      o_wb.rdt = rdt_q;
      o_wb.ack = ack_q;
      o_wb.err = 1'b0;
   end

   assign o_irq = ctrl_q[CTRL_INT] & ctrl_q[CTRL_IE];

endmodule

`default_nettype wire

// File: source/wb_pkg.sv
`default_nettype none

package wb_pkg;

   // ********************
   // Bus widths
   // ********************

   localparam int WB_ADR_W = 16;
   localparam int WB_DAT_W = 32;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   typedef logic [WB_DAT_W-1:0] wb_word_t;

   // Master to slave
   typedef struct packed {
      wb_adr_t  adr;
      wb_word_t dat;
      logic     we;
      logic     cyc;
      logic     stb;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      wb_word_t rdt;
      logic     ack;
      logic     err;
   } wb_rsp_t;

endpackage

`default_nettype wire

// File: tests/swervolf_io_assert.sv
`default_nettype none

module swervolf_io_assert (
   input logic            i_clk,
   input logic            i_reset,
   input wb_pkg::wb_req_t i_req,
   input wb_pkg::wb_rsp_t i_rsp
);
   timeunit 1ns;
   timeprecision 100ps;

   ack_err_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
      !(i_rsp.ack && i_rsp.err))
      else $error("ack and err high in the same cycle");

   // Every response answers a strobe one cycle earlier
   resp_after_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_rsp.ack || i_rsp.err) |-> $past(i_req.cyc && i_req.stb))
      else $error("response without a preceding cyc and stb");

   ack_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
      i_rsp.ack |=> !i_rsp.ack)
      else $error("ack held high for two cycles");

endmodule

bind io_intercon swervolf_io_assert bus_checks (
   .i_clk   (i_clk),
   .i_reset (i_reset),
   .i_req   (i_wb),
   .i_rsp   (o_wb)
);

`default_nettype wire

// File: tests/tb_swervolf_io.sv
`default_nettype none

module tb_swervolf_io;
   timeunit 1ns;
   timeprecision 100ps;

   import wb_pkg::*;
   import io_map_pkg::*;

   localparam int MAX_CYCLES = 2000;

   logic       clk;
   logic       reset;
   wb_req_t    req;
   wb_rsp_t    rsp_w;
   gpio_pins_t gpio_in;
   gpio_pins_t gpio_out;
   gpio_pins_t gpio_oe;
   io_irq_t    irq;
   wb_word_t   rng = 32'h9557_14cf;
   int         cycle = 0;
   int         checks = 0;
   int         errors = 0;

   swervolf_io dut0 (
      .i_clk      (clk),
      .i_reset    (reset),
      .i_wb       (req),
      .o_wb       (rsp_w),
      .i_gpio_in  (gpio_in),
      .o_gpio_out (gpio_out),
      .o_gpio_oe  (gpio_oe),
      .o_irq      (irq)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("** FAIL **");
         $finish;
      end
   end

   // ********************
   // Helpers
   // ********************

   function automatic wb_word_t xorshift32(input wb_word_t s);
      wb_word_t x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic wb_adr_t gpio_addr(input ofs_t ofs);
      return GPIO_BASE | wb_adr_t'(ofs);
   endfunction

   function automatic wb_adr_t timer_addr(input ofs_t ofs);
      return TIMER_BASE | wb_adr_t'(ofs);
   endfunction

   function automatic wb_word_t ctrl_bits(input logic en, input logic ie, input logic irq_flag);
      wb_word_t w;
      w = '0;
      w[CTRL_EN]  = en;
      w[CTRL_IE]  = ie;
      w[CTRL_INT] = irq_flag;
      return w;
   endfunction

   task automatic next_random(output wb_word_t r);
      rng = xorshift32(rng);
      r = rng;
   endtask

   task automatic drive_pins(input gpio_pins_t p);
      @(posedge clk);
      gpio_in <= p;
   endtask

   task automatic check_word(input string name, input wb_word_t got, input wb_word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pins(input string name, input gpio_pins_t got, input gpio_pins_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_irq(input string name, input io_irq_t got, input io_irq_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // ********************
   // Bus cycles
   // ********************

   // Response is due at the second falling edge after the strobe
   task automatic bus_transfer(input wb_adr_t adr, input logic we, input wb_word_t dat,
                               output wb_rsp_t rsp);
      int waited;
      waited = 0;
      rsp = '0;
      @(posedge clk);
      req <= '{adr: adr, dat: dat, we: we, cyc: 1'b1, stb: 1'b1};
      while (!(rsp.ack || rsp.err) && waited < 8) begin
         @(negedge clk);
         rsp = rsp_w;
         waited++;
      end
      if (waited != 2) begin
         errors++;
         $display("ERROR t=%0t bus cycle at %h got no response one clock after strobe",
                  $time, adr);
      end
      @(posedge clk);
      req <= '0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_word_t dat);
      wb_rsp_t rsp;
      bus_transfer(adr, 1'b1, dat, rsp);
      check_err("err on write", rsp.err, 1'b0);
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_word_t data);
      wb_rsp_t rsp;
      bus_transfer(adr, 1'b0, '0, rsp);
      check_err("err on read", rsp.err, 1'b0);
      data = rsp.rdt;
   endtask

   // ********************
   // Directed tests
   // ********************

   task automatic reset_values();
      wb_adr_t  regs[7];
      wb_word_t data;
      regs = '{gpio_addr(GPIO_OUT), gpio_addr(GPIO_OE), gpio_addr(GPIO_INTE),
               gpio_addr(GPIO_INTS), timer_addr(TMR_CNTR), timer_addr(TMR_HRC),
               timer_addr(TMR_CTRL)};
      @(negedge clk);
      check_pins("o_gpio_out", gpio_out, '0);
      check_pins("o_gpio_oe", gpio_oe, '0);
      check_irq("o_irq", irq, '0);
      foreach (regs[i]) begin
         wb_read(regs[i], data);
         check_word($sformatf("register %h after reset", regs[i]), data, '0);
      end
   endtask

   task automatic gpio_readback();
      wb_word_t out_val;
      wb_word_t oe_val;
      wb_word_t data;
      repeat (4) begin
         next_random(out_val);
         next_random(oe_val);
         wb_write(gpio_addr(GPIO_OUT), out_val);
         wb_write(gpio_addr(GPIO_OE), oe_val);
         @(negedge clk);
         check_pins("o_gpio_out", gpio_out, out_val);
         check_pins("o_gpio_oe", gpio_oe, oe_val);
         wb_read(gpio_addr(GPIO_OUT), data);
         check_word("GPIO_OUT", data, out_val);
         wb_read(gpio_addr(GPIO_OE), data);
         check_word("GPIO_OE", data, oe_val);
      end
   endtask

   task automatic gpio_interrupts();
      wb_word_t   data;
      gpio_pins_t pins;
      gpio_pins_t mask;
      next_random(pins);
      drive_pins(pins);
      repeat (2) @(posedge clk);
      wb_read(gpio_addr(GPIO_IN), data);
      check_word("GPIO_IN", data, pins);
      // Idle pins and a clean INTS before the edge tests
      drive_pins('0);
      repeat (2) @(posedge clk);
      wb_write(gpio_addr(GPIO_INTS), '1);
      wb_read(gpio_addr(GPIO_INTS), data);
      check_word("GPIO_INTS after clear", data, '0);
      next_random(mask);
      mask = (mask & 32'h7fff_ffff) | 32'h1;
      wb_write(gpio_addr(GPIO_INTE), mask);
      drive_pins(mask);
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_irq("o_irq on enabled edges", irq, '{gpio: 1'b1, timer: 1'b0});
      wb_read(gpio_addr(GPIO_INTS), data);
      check_word("GPIO_INTS after edges", data, mask);
      wb_write(gpio_addr(GPIO_INTS), mask);
      @(negedge clk);
      check_irq("o_irq after INTS clear", irq, '0);
      // Pin 31 is left out of INTE
      drive_pins(mask | 32'h8000_0000);
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_irq("o_irq on masked edge", irq, '0);
      wb_read(gpio_addr(GPIO_INTS), data);
      check_word("GPIO_INTS after masked edge", data, 32'h8000_0000);
      drive_pins('0);
      wb_write(gpio_addr(GPIO_INTE), '0);
      wb_write(gpio_addr(GPIO_INTS), '1);
   endtask

   task automatic timer_compare();
      wb_word_t data;
      int       start;
      wb_write(timer_addr(TMR_HRC), 32'd20);
      wb_write(timer_addr(TMR_CTRL), ctrl_bits(1'b1, 1'b1, 1'b0));
      start = cycle;
      @(negedge clk);
      while (!irq.timer && cycle - start < 40) begin
         wb_read(timer_addr(TMR_CNTR), data);
         checks++;
         if (data > 32'd20) begin
            errors++;
            $display("CHECK FAILED t=%0t TMR_CNTR got %0d expected at most 20", $time, data);
         end
         @(negedge clk);
      end
      check_irq("o_irq after compare match", irq, '{gpio: 1'b0, timer: 1'b1});
      wb_read(timer_addr(TMR_CTRL), data);
      check_word("TMR_CTRL after match", data, ctrl_bits(1'b1, 1'b1, 1'b1));
      wb_write(timer_addr(TMR_CTRL), ctrl_bits(1'b1, 1'b1, 1'b1));
      @(negedge clk);
      check_irq("o_irq after INT clear", irq, '0);
      // INT still sets on the next match with IE off
      wb_write(timer_addr(TMR_CTRL), ctrl_bits(1'b1, 1'b0, 1'b1));
      start = cycle;
      data = '0;
      while (!data[CTRL_INT] && cycle - start < 40) begin
         wb_read(timer_addr(TMR_CTRL), data);
         @(negedge clk);
         check_irq("o_irq with IE clear", irq, '0);
      end
      check_word("TMR_CTRL with IE clear", data, ctrl_bits(1'b1, 1'b0, 1'b1));
      wb_write(timer_addr(TMR_CTRL), ctrl_bits(1'b0, 1'b0, 1'b1));
   endtask

   task automatic unmapped_access();
      wb_adr_t  bad[4];
      wb_word_t out_val;
      wb_word_t data;
      wb_rsp_t  rsp;
      // Offset 4 would land on OUT or HRC if a slave took the write
      bad = '{16'h0300, 16'h0000, 16'h0304, 16'h0004};
      next_random(out_val);
      wb_write(gpio_addr(GPIO_OUT), out_val);
      wb_write(timer_addr(TMR_CNTR), 32'h0000_1234);
      foreach (bad[i]) begin
         bus_transfer(bad[i], 1'b1, 32'hffff_ffff, rsp);
         check_err("err on unmapped write", rsp.err, 1'b1);
         check_err("ack on unmapped write", rsp.ack, 1'b0);
         bus_transfer(bad[i], 1'b0, '0, rsp);
         check_err("err on unmapped read", rsp.err, 1'b1);
         check_err("ack on unmapped read", rsp.ack, 1'b0);
         check_word("unmapped read data", rsp.rdt, '0);
      end
      wb_read(gpio_addr(GPIO_OUT), data);
      check_word("GPIO_OUT after unmapped writes", data, out_val);
      wb_read(timer_addr(TMR_CNTR), data);
      check_word("TMR_CNTR after unmapped writes", data, 32'h0000_1234);
      wb_read(timer_addr(TMR_HRC), data);
      check_word("TMR_HRC after unmapped writes", data, 32'd20);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      req = '0;
      gpio_in = '0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      reset_values();
      gpio_readback();
      gpio_interrupts();
      timer_compare();
      unmapped_access();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
